// ==== tb.f ====
+incdir+rtl
rtl/servo_data_pkg.sv
rtl/servo_cfg_pkg.sv
rtl/opp_param_if.sv
rtl/channel_mux.sv
rtl/opp_param_bank.sv
rtl/output_preprocessor.sv
rtl/servo_output_top.sv
test/tb_servo_output.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the servo output stage testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f \
	--top-module tb_servo_output \
	-o tb_servo_output

# the pipe keeps a nonzero simulator exit from skipping the log search
./obj_dir/tb_servo_output 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation passed"

// ==== test/tb_servo_output.sv ====
`default_nettype none

`include "servo_consts.svh"

module tb_servo_output
	import servo_data_pkg::*, servo_cfg_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////
	// row format
	////////////////////////////////////////////////////////////

	typedef enum {KIND_SAMPLE, KIND_UPDATE, KIND_BUSY} kind_t;

	typedef struct {
		string       name;			// test name for error lines
		kind_t       kind;			// sample, parameter update or busy drop
		chan_sel_t   chan;			// selected channel
		adc_sample_t value;			// sample on the selected channel
		logic        lock;			// lock_en during the row
		opp_cfg_t    cfg;			// front panel values for updates
		logic        upd_en;		// update_en during the update pulse
		logic        expect_out;	// a data_valid strobe is due
		out_word_t   expected;		// hand computed output word
	} vec_t;

	localparam adc_sample_t BUSY_VALUE = adc_sample_t'(40000);	// dropped sample of 10000 narrowed

	logic                            clk_in;
	logic                            reset_in;
	adc_sample_t [`SERVO_N_CHAN-1:0] chan_data;
	logic                            chan_valid;
	chan_sel_t                       chan_sel;
	logic                            lock_en;
	out_word_t                       output_max;
	out_word_t                       output_min;
	out_word_t                       output_init;
	gain_t                           multiplier;
	logic                            update_en;
	logic                            update;
	out_word_t                       data;
	logic                            data_valid;

	vec_t        vectors [$];		// stimulus table
	int          cycle_count = 0;	// edges since start
	int          cycle_limit = 50;	// set from the table size

	servo_output_top u_dut (
		.clk_in, .reset_in, .chan_data, .chan_valid, .chan_sel, .lock_en,
		.output_max, .output_min, .output_init, .multiplier, .update_en, .update,
		.data, .data_valid
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;	// 10 ns period
	end

	////////////////////////////////////////////////////////////
	// failure handling
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	// hard stop on a hung run
	always @(posedge clk_in) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, stimulus did not complete", cycle_count);
			abort_run();
		end
	end

	task automatic check_word(input string name, input out_word_t expected);
		if (data_valid !== 1'b1) begin
			$display("no data_valid strobe where one was due in %s", name);
			abort_run();
		end else if (data !== expected) begin
			$display("FAIL %s: expected %0d, actual %0d", name, expected, data);
			abort_run();
		end
	endtask

	// strobe sampled 1 ns after each edge must stay low
	task automatic check_quiet(input string name, input int cycles);
		repeat (cycles) begin
			@(posedge clk_in);
			#1;
			if (data_valid !== 1'b0) begin
				$display("unexpected data_valid strobe during %s", name);
				abort_run();
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic add_row(input string name, input kind_t kind, input int chan,
		input int value, input logic lock, input int omax, input int omin, input int oinit,
		input int gain, input logic upd_en, input logic expect_out, input int expected);
		vec_t v;
		v.name       = name;
		v.kind       = kind;
		v.chan       = chan_sel_t'(chan);
		v.value      = adc_sample_t'(value);
		v.lock       = lock;
		v.cfg        = '{out_max: out_word_t'(omax), out_min: out_word_t'(omin),
			out_init: out_word_t'(oinit), gain: gain_t'(gain)};
		v.upd_en     = upd_en;
		v.expect_out = expect_out;
		v.expected   = out_word_t'(expected);
		vectors.push_back(v);
	endtask

	// expected words follow narrow, gain, accumulate, lock select, clamp
	task automatic load_vectors();
		//      name               kind         ch value    lk max    min     init gain en ex out
		add_row("reset_defaults",  KIND_SAMPLE, 0, 400,     1, 0,     0,      0,    0,  0, 1, 5100);
		add_row("accumulate",      KIND_SAMPLE, 0, 400,     1, 0,     0,      0,    0,  0, 1, 5200);
		add_row("update_gain50",   KIND_UPDATE, 0, 0,       1, 9999,  1111,   5000, 50, 1, 0, 0);
		add_row("gain_clamp_hi",   KIND_SAMPLE, 0, 400,     1, 0,     0,      0,    0,  0, 1, 9999);
		add_row("gain_clamp_lo",   KIND_SAMPLE, 0, -2000,   1, 0,     0,      0,    0,  0, 1, 1111);
		add_row("unlocked",        KIND_SAMPLE, 0, 1234,    0, 0,     0,      0,    0,  0, 1, 5000);
		add_row("update_disabled", KIND_UPDATE, 0, 0,       0, 2000,  0,      100,  2,  0, 0, 0);
		add_row("update_ignored",  KIND_SAMPLE, 0, 400,     1, 0,     0,      0,    0,  0, 1, 9999);
		add_row("update_full",     KIND_UPDATE, 0, 0,       1, 32767, -32768, 0,    255, 1, 0, 0);
		add_row("product_sat",     KIND_SAMPLE, 0, 131071,  1, 0,     0,      0,    0,  0, 1, 32767);
		add_row("sum_sat",         KIND_SAMPLE, 0, 131071,  1, 0,     0,      0,    0,  0, 1, 32767);
		add_row("update_chan",     KIND_UPDATE, 0, 0,       1, 9999,  -9999,  0,    1,  1, 0, 0);
		add_row("chan2_select",    KIND_SAMPLE, 2, 4000,    1, 0,     0,      0,    0,  0, 1, 1000);
		add_row("busy_drop",       KIND_BUSY,   1, 800,     1, 0,     0,      0,    0,  0, 1, 1200);
		add_row("after_drop",      KIND_SAMPLE, 1, 800,     1, 0,     0,      0,    0,  0, 1, 1400);
	endtask

	// random filler never equal to the wanted value
	task automatic fill_channels(input chan_sel_t chan, input adc_sample_t value);
		adc_sample_t r;
		for (int c = 0; c < `SERVO_N_CHAN; c++) begin
			r = adc_sample_t'($urandom);
			while (r == value) r = adc_sample_t'($urandom);
			chan_data[c] = r;
		end
		chan_data[chan] = value;	// selected channel carries the test value
	endtask

	// one cycle chan_valid pulse ending 1 ns after its edge
	task automatic pulse_valid();
		chan_valid = 1'b1;
		@(posedge clk_in);
		#1 chan_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// row execution in 8 cycle slots
	////////////////////////////////////////////////////////////

	task automatic apply_row(input vec_t v);
		case (v.kind)
			KIND_UPDATE: begin
				output_max  = v.cfg.out_max;
				output_min  = v.cfg.out_min;
				output_init = v.cfg.out_init;
				multiplier  = v.cfg.gain;
				update_en   = v.upd_en;
				update      = 1'b1;
				@(posedge clk_in);
				#1;
				update    = 1'b0;
				update_en = 1'b0;
				check_quiet(v.name, 7);	// updates never strobe the output
			end
			KIND_BUSY: begin
				fill_channels(v.chan, v.value);
				chan_sel = v.chan;
				lock_en  = v.lock;
				pulse_valid();
				@(posedge clk_in);
				#1 fill_channels(v.chan, BUSY_VALUE);
				pulse_valid();				// lands 2 cycles after the first
				repeat (3) @(posedge clk_in);
				#1 check_word(v.name, v.expected);
				check_quiet(v.name, 2);		// covers a strobe for the second one
			end
			default: begin
				fill_channels(v.chan, v.value);
				chan_sel = v.chan;
				lock_en  = v.lock;
				pulse_valid();
				repeat (5) @(posedge clk_in);	// fixed 5 cycle latency
				#1;
				if (v.expect_out) begin
					check_word(v.name, v.expected);
				end else begin
					check_quiet(v.name, 1);
				end
				check_quiet(v.name, 2);
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h1c76));	// one seed for the whole run
		reset_in    = 1'b1;
		chan_data   = '0;
		chan_valid  = 1'b0;
		chan_sel    = '0;
		lock_en     = 1'b0;
		output_max  = '0;
		output_min  = '0;
		output_init = '0;
		multiplier  = '0;
		update_en   = 1'b0;
		update      = 1'b0;

		load_vectors();
		cycle_limit = vectors.size() * 10 + 50;	// margin over 8 cycles per row

		repeat (5) @(posedge clk_in);
		#1 reset_in = 1'b0;

		foreach (vectors[i]) begin
			apply_row(vectors[i]);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/servo_output_top.sv ====
`default_nettype none

`include "servo_consts.svh"

module servo_output_top
	import servo_data_pkg::*, servo_cfg_pkg::*;
(
	input  logic                            clk_in,			// system clock
	input  logic                            reset_in,		// sync reset, active high

	input  adc_sample_t [`SERVO_N_CHAN-1:0] chan_data,		// error channels
	input  logic                            chan_valid,		// new samples
	input  chan_sel_t                       chan_sel,		// channel to lock on
	input  logic                            lock_en,		// lock loop closed

	input  out_word_t                       output_max,		// front panel upper bound
	input  out_word_t                       output_min,		// front panel lower bound
	input  out_word_t                       output_init,	// front panel start value
	input  gain_t                           multiplier,		// front panel gain
	input  logic                            update_en,		// arms update
	input  logic                            update,			// load front panel values

	output out_word_t                       data,			// to dac/dds side
	output logic                            data_valid		// output strobe
);

	adc_sample_t sample;		// mux to preprocessor
	logic        sample_valid;

	opp_param_if u_param_if ();

	channel_mux #(.N_CHAN(`SERVO_N_CHAN)) u_mux (
		.clk_in, .reset_in, .chan_data, .chan_valid, .chan_sel,
		.sample, .sample_valid
	);

	opp_param_bank u_params (
		.clk_in, .reset_in, .output_max, .output_min, .output_init,
		.multiplier, .update_en, .update, .params(u_param_if.source)
	);

	output_preprocessor #(.COMP_LATENCY(`OPP_COMP_LATENCY)) u_opp (
		.clk_in, .reset_in, .sample, .sample_valid, .lock_en,
		.params(u_param_if.sink), .data_out(data), .data_valid
	);

endmodule

`default_nettype wire

// ==== rtl/output_preprocessor.sv ====
`default_nettype none

`include "servo_consts.svh"

module output_preprocessor
	import servo_data_pkg::*;
#(
	parameter int COMP_LATENCY = `OPP_COMP_LATENCY	// cycles in compute
) (
	input  logic        clk_in,			// system clock
	input  logic        reset_in,		// sync reset, active high

	input  adc_sample_t sample,			// selected error sample
	input  logic        sample_valid,	// one cycle strobe from the mux
	input  logic        lock_en,		// low holds output at out_init

	opp_param_if.sink   params,			// active configuration

	output out_word_t   data_out,		// word to dac/dds side
	output logic        data_valid		// one cycle strobe
);

	////////////////////////////////////////////////////////////
	// local constants
	////////////////////////////////////////////////////////////

	localparam int W_OUT  = `SERVO_W_OUT;
	localparam int W_IN   = `SERVO_W_IN;
	localparam int W_PROD = W_OUT + 9;	// 16 bit signed times 9 bit signed gain
	localparam int W_HEAD = W_PROD - W_OUT + 1;	// bits that must match the sign
	localparam int CNT_W  = (COMP_LATENCY > 0) ? $clog2(COMP_LATENCY + 1) : 1;

	localparam out_word_t OUT_POS_MAX = {1'b0, {(W_OUT-1){1'b1}}};	// +32767
	localparam out_word_t OUT_NEG_MAX = {1'b1, {(W_OUT-1){1'b0}}};	// -32768

	typedef enum logic [1:0] {
		ST_IDLE,	// wait for a sample
		ST_COMPUTE,	// fixed latency
		ST_SEND,	// strobe the result
		ST_DONE		// store result as previous output
	} opp_state_t;

	opp_state_t                state_q;		// current state
	opp_state_t                state_d;		// next state
	logic       [CNT_W-1:0]    counter;		// intrastate counter

	out_word_t                 lock_data;	// narrowed sample
	out_word_t                 prev_q;		// previous output

	logic signed [W_PROD-1:0]  prod_full;	// exact product
	logic                      prod_ovf;
	out_word_t                 prod_sat;
	logic signed [W_OUT:0]     sum_full;	// one guard bit
	logic                      sum_ovf;
	out_word_t                 sum_sat;
	out_word_t                 lock_sel;	// after lock select
	out_word_t                 clamp_hi;	// after upper bound
	out_word_t                 result;		// after lower bound

	////////////////////////////////////////////////////////////
	// output arithmetic
	////////////////////////////////////////////////////////////

	// gain, saturate on overflow
	assign prod_full = lock_data * $signed({1'b0, params.cfg.gain});
	assign prod_ovf  = prod_full[W_PROD-1 -: W_HEAD] != {W_HEAD{prod_full[W_PROD-1]}};
	assign prod_sat  = prod_ovf ? (prod_full[W_PROD-1] ? OUT_NEG_MAX : OUT_POS_MAX)
		: prod_full[W_OUT-1:0];

	// accumulate onto previous output
	assign sum_full = prod_sat + prev_q;
	assign sum_ovf  = sum_full[W_OUT] != sum_full[W_OUT-1];	// guard differs from sign
	assign sum_sat  = sum_ovf ? (sum_full[W_OUT] ? OUT_NEG_MAX : OUT_POS_MAX)
		: sum_full[W_OUT-1:0];

	assign lock_sel = lock_en ? sum_sat : params.cfg.out_init;	// unlocked holds start
	assign clamp_hi = (lock_sel < params.cfg.out_max) ? lock_sel : params.cfg.out_max;
	assign result   = (clamp_hi > params.cfg.out_min) ? clamp_hi : params.cfg.out_min;

	assign data_valid = (state_q == ST_SEND);

	////////////////////////////////////////////////////////////
	// data registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (state_q == ST_IDLE && sample_valid) begin
			lock_data <= out_word_t'(sample[W_IN-1 -: W_OUT]);	// drop the lsbs
		end
		if (state_q == ST_COMPUTE && counter == CNT_W'(COMP_LATENCY)) begin
			data_out <= result;	// held until the next strobe
		end
	end

	// previous output, restart wins over done
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev_q <= out_word_t'(`OPP_OINIT_INIT);
		end else if (params.load_prev) begin
			prev_q <= params.cfg.out_init;
		end else if (state_q == ST_DONE) begin
			prev_q <= data_out;
		end
	end

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:    if (sample_valid) state_d = ST_COMPUTE;	// accept
			ST_COMPUTE: if (counter == CNT_W'(COMP_LATENCY)) state_d = ST_SEND;
			ST_SEND:    state_d = ST_DONE;
			ST_DONE:    state_d = ST_IDLE;
			default:    state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state_q <= ST_IDLE;
			counter <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_COMPUTE && state_d == ST_COMPUTE) begin
				counter <= counter + 1'b1;
			end else begin
				counter <= '0;	// restart on every state change
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	a_valid_pulse: assert property (
		@(posedge clk_in) disable iff (reset_in)
		data_valid |=> !data_valid
	) else $error("output_preprocessor: data_valid longer than one cycle");

	// bounds as they were when the word was registered
	a_out_bounded: assert property (
		@(posedge clk_in) disable iff (reset_in)
		data_valid && ($past(params.cfg.out_min) <= $past(params.cfg.out_max)) |->
			(data_out >= $past(params.cfg.out_min)) &&
			(data_out <= $past(params.cfg.out_max))
	) else $error("output_preprocessor: data_out %0d outside bounds", data_out);

endmodule

`default_nettype wire

// ==== rtl/opp_param_bank.sv ====
`default_nettype none

`include "servo_consts.svh"

module opp_param_bank
	import servo_data_pkg::*, servo_cfg_pkg::*;
(
	input  logic       clk_in,		// system clock
	input  logic       reset_in,	// sync reset, active high

	// front panel values
	input  out_word_t  output_max,	// new upper bound
	input  out_word_t  output_min,	// new lower bound
	input  out_word_t  output_init,	// new start value
	input  gain_t      multiplier,	// new gain
	input  logic       update_en,	// arms the update pulse
	input  logic       update,		// take new values

	opp_param_if.source params		// active configuration out
);

	////////////////////////////////////////////////////////////
	// reset defaults
	////////////////////////////////////////////////////////////

	localparam opp_cfg_t CFG_RESET = '{
		out_max:  out_word_t'(`OPP_OMAX_INIT),
		out_min:  out_word_t'(`OPP_OMIN_INIT),
		out_init: out_word_t'(`OPP_OINIT_INIT),
		gain:     gain_t'(`OPP_MULT_INIT)
	};

	opp_cfg_t cfg_q;	// active configuration
	logic     take;		// gated update request
	logic     take_q;	// request seen last cycle
	logic     load_q;	// accumulator restart pulse

	assign take = update & update_en;	// ignored unless enabled

	////////////////////////////////////////////////////////////
	// shadow registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cfg_q  <= CFG_RESET;
			take_q <= 1'b0;
			load_q <= 1'b0;
		end else begin
			if (take) begin
				cfg_q <= '{out_max: output_max, out_min: output_min,
					out_init: output_init, gain: multiplier};	// all four at once
			end
			take_q <= take;
			load_q <= take & ~take_q;	// first cycle of a request only
		end
	end

	assign params.cfg       = cfg_q;
	assign params.load_prev = load_q;

	// restart request stays a single cycle even for a long update
	a_load_single: assert property (
		@(posedge clk_in) disable iff (reset_in)
		load_q |=> !load_q
	) else $error("opp_param_bank: load_prev longer than one cycle");

endmodule

`default_nettype wire

// ==== rtl/channel_mux.sv ====
`default_nettype none

`include "servo_consts.svh"

module channel_mux
	import servo_data_pkg::*;
#(
	parameter int N_CHAN = `SERVO_N_CHAN	// number of selectable channels
) (
	input  logic                     clk_in,		// system clock
	input  logic                     reset_in,		// sync reset, active high

	input  adc_sample_t [N_CHAN-1:0] chan_data,		// all error channels
	input  logic                     chan_valid,	// new samples on chan_data
	input  chan_sel_t                chan_sel,		// channel to forward

	output adc_sample_t              sample,		// registered selected channel
	output logic                     sample_valid	// one cycle strobe
);

	////////////////////////////////////////////////////////////
	// selection register
	////////////////////////////////////////////////////////////

	// selected channel latched with its strobe
	always_ff @(posedge clk_in) begin
		if (chan_valid) begin
			sample <= chan_data[chan_sel];	// latch chosen channel
		end
	end

	// strobe cleared on reset
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= chan_valid;	// one cycle behind the input
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// front panel must not point past the last channel
	a_sel_in_range: assert property (
		@(posedge clk_in) disable iff (reset_in)
		chan_valid |-> (chan_sel < N_CHAN)
	) else $error("channel_mux: chan_sel %0d out of range", chan_sel);

endmodule

`default_nettype wire

// ==== rtl/opp_param_if.sv ====
`default_nettype none

// configuration link between parameter bank and preprocessor
interface opp_param_if
	import servo_cfg_pkg::*;
();

	opp_cfg_t cfg;		// active bounds, start value, gain
	logic     load_prev;	// one cycle, restart accumulator from cfg.out_init

	// parameter bank side
	modport source (
		output cfg,
		output load_prev
	);

	// preprocessor side
	modport sink (
		input cfg,
		input load_prev
	);

endinterface

`default_nettype wire

// ==== rtl/servo_cfg_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// output configuration types
////////////////////////////////////////////////////////////

package servo_cfg_pkg;

	import servo_data_pkg::*;

	// unsigned gain applied to the narrowed error
	typedef logic [7:0] gain_t;

	// active output configuration
	typedef struct packed {
		out_word_t out_max;	// clamp ceiling
		out_word_t out_min;	// clamp floor
		out_word_t out_init;	// start value and unlocked output
		gain_t     gain;	// error multiplier
	} opp_cfg_t;

endpackage

`default_nettype wire

// ==== rtl/servo_data_pkg.sv ====
`default_nettype none

`include "servo_consts.svh"

////////////////////////////////////////////////////////////
// sample path types
////////////////////////////////////////////////////////////

package servo_data_pkg;

	// raw error sample from the adc side
	typedef logic signed [`SERVO_W_IN-1:0] adc_sample_t;

	// word handed to the dac/dds side
	typedef logic signed [`SERVO_W_OUT-1:0] out_word_t;

	// channel index, at least one bit wide
	typedef logic [((`SERVO_N_CHAN > 1) ? $clog2(`SERVO_N_CHAN) : 1)-1:0] chan_sel_t;

endpackage

`default_nettype wire

// ==== rtl/servo_consts.svh ====
`ifndef SERVO_CONSTS_SVH
`define SERVO_CONSTS_SVH

////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////

`define SERVO_W_IN        18    // adc sample width
`define SERVO_W_OUT       16    // dac/dds output word width
`define SERVO_N_CHAN      4     // error channels from the adc side

`define OPP_COMP_LATENCY  3     // cycles in the compute state

////////////////////////////////////////////////////////////
// front panel reset values
////////////////////////////////////////////////////////////

`define OPP_OMAX_INIT     9999  // upper output bound
`define OPP_OMIN_INIT     1111  // lower output bound
`define OPP_OINIT_INIT    5000  // start value of the accumulator
`define OPP_MULT_INIT     1     // unity gain

`endif
